/* sim.f */
logic/ctn_pkg.sv
logic/por_sequencer.sv
logic/ctn_host_arbiter.sv
logic/ctn_sram_adapter.sv
logic/ctn_ram.sv
logic/ctn_subsys_top.sv
verif/ctn_subsys_tb.sv

/* Bender.yml */
package:
  name: ctn_subsys

sources:
  - logic/ctn_pkg.sv
  - logic/por_sequencer.sv
  - logic/ctn_host_arbiter.sv
  - logic/ctn_sram_adapter.sv
  - logic/ctn_ram.sv
  - logic/ctn_subsys_top.sv
  - target: simulation
    files:
      - verif/ctn_subsys_tb.sv

/* verif/ctn_subsys_tb.sv */
////////////////////////////////////////
// Testbench for the CTN subsystem top level
// Random two-host traffic checked against a RAM model
////////////////////////////////////////

`timescale 1ns/1ps

module ctn_subsys_tb;

  import ctn_pkg::*;

  localparam int NumReqs       = 200;  // Per host
  localparam int TimeoutCycles = CtnNumHosts * NumReqs * 10 + 200;
  localparam int PorCheckLen   = 13;   // Through the first steady-high cycle
  localparam int HostStart     = 9;    // First cycle of the dip

  logic                       clk_aon;
  logic                       rst_n_i;
  logic [CtnNumHosts-1:0]     host_valid;
  ctn_req_t [CtnNumHosts-1:0] host_req;
  logic [CtnNumHosts-1:0]     host_ready;
  logic                       rsp_valid;
  ctn_rsp_t                   rsp;
  logic                       pok;

  int                     seed;
  int                     cycles;
  int                     issued [CtnNumHosts];
  int                     responses;
  int                     reads_checked;
  logic [CtnNumHosts-1:0] xfer;       // Handshakes that complete at the next edge
  logic                   have_last;
  int                     last_host;

  // RAM model, one written flag per byte
  logic [CtnDataW-1:0] model_mem   [2**CtnRamAw];
  logic [CtnMaskW-1:0] model_known [2**CtnRamAw];

  ctn_rsp_t            exp_q   [CtnNumHosts][$];
  logic [CtnMaskW-1:0] known_q [CtnNumHosts][$];
  int                  due_q   [$];  // Cycle in which each response is sampled
  int                  order_q [$];

  ctn_subsys_top dut_i (
    .clk_aon         (clk_aon),
    .rst_n_i         (rst_n_i),
    .host_valid_i    (host_valid),
    .host_req_i      (host_req),
    .host_ready_o    (host_ready),
    .ctn_rsp_valid_o (rsp_valid),
    .ctn_rsp_o       (rsp),
    .pok_o           (pok)
  );

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic match_rsp(input ctn_rsp_t got, input ctn_rsp_t exp,
                           input logic [CtnMaskW-1:0] known);
    logic [CtnDataW-1:0] keep;
    for (int b = 0; b < CtnMaskW; b++) keep[8*b +: 8] = {8{known[b]}};
    if (got.host_id !== exp.host_id)
      report_failure($sformatf("ERROR: ctn_rsp_o.host_id = 0x%0h, expected 0x%0h",
                               got.host_id, exp.host_id));
    if (got.err !== exp.err)
      report_failure($sformatf("ERROR: ctn_rsp_o.err = 0x%0h, expected 0x%0h",
                               got.err, exp.err));
    if ((got.rdata & keep) !== (exp.rdata & keep))
      report_failure($sformatf("ERROR: ctn_rsp_o.rdata = 0x%08h, expected 0x%08h (bytes 0x%0h)",
                               got.rdata, exp.rdata, known));
  endtask

  ////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////

  // Low 4, high 4, low 4, then high for good
  function automatic logic pok_pattern(input int k);
    return (k >= 4 && k < 8) || (k >= 12);
  endfunction

  function automatic logic in_window(input logic [CtnAddrW-1:0] addr);
    return (addr >= CtnRamBase) && (addr < CtnRamBase + CtnAddrW'(CtnRamSizeBytes));
  endfunction

  function automatic ctn_req_t next_request(input int host);
    ctn_req_t            req;
    logic [CtnRamAw-1:0] word;
    word        = CtnRamAw'($random(seed) & 31);  // Small working set so reads hit writes
    req.op      = ($random(seed) & 1) ? CtnWrite : CtnRead;
    req.wdata   = $random(seed);
    req.wmask   = CtnMaskW'($random(seed));
    req.host_id = CtnHostIdW'(host);
    if ((($random(seed) & 32'h7fff_ffff) % 10) < 8) begin
      req.addr = CtnRamBase + {word, 2'($random(seed))};
    end else if ($random(seed) & 1) begin
      req.addr = CtnRamBase + CtnAddrW'(CtnRamSizeBytes) + {word, 2'b00};  // Aliases a word
    end else begin
      req.addr = $random(seed);
      if (in_window(req.addr)) req.addr[31] = ~req.addr[31];
    end
    return req;
  endfunction

  // Round robin, the host after the last winner goes first
  function automatic logic [CtnNumHosts-1:0] rr_grant(input logic [CtnNumHosts-1:0] valid);
    logic [CtnNumHosts-1:0] gnt;
    int                     cand;
    if (!have_last) return valid & (~valid + 1'b1);  // Lowest index wins the first tie
    gnt = '0;
    for (int i = 1; i <= CtnNumHosts; i++) begin
      cand = (last_host + i) % CtnNumHosts;
      if (gnt == '0 && valid[cand]) gnt[cand] = 1'b1;
    end
    return gnt;
  endfunction

  task automatic record_transfer(input int h);
    ctn_req_t            req;
    ctn_rsp_t            exp;
    logic [CtnMaskW-1:0] known;
    logic [CtnRamAw-1:0] word;
    req         = host_req[h];
    word        = req.addr[CtnRamAw+1:2];
    exp         = '0;
    exp.host_id = CtnHostIdW'(h);
    exp.err     = !in_window(req.addr);
    known       = '1;
    if (!exp.err && req.op == CtnWrite) begin
      for (int b = 0; b < CtnMaskW; b++) begin
        if (req.wmask[b]) begin
          model_mem[word][8*b +: 8] = req.wdata[8*b +: 8];
          model_known[word][b]      = 1'b1;
        end
      end
    end else if (!exp.err) begin
      exp.rdata = model_mem[word];
      known     = model_known[word];
      if (known != '0) reads_checked++;
    end
    exp_q[h].push_back(exp);
    known_q[h].push_back(known);
    due_q.push_back(cycles + CtnRspLatency);
    order_q.push_back(h);
    last_host = h;
    have_last = 1'b1;
  endtask

  // Runs mid-cycle, after the posedge updates have settled
  task automatic sample_cycle();
    logic [CtnNumHosts-1:0] exp_ready;
    logic                   due;
    int                     h;
    exp_ready = rr_grant(host_valid);
    for (int i = 0; i < CtnNumHosts; i++)
      expect_bit($sformatf("host_ready_o[%0d]", i), host_ready[i], exp_ready[i]);
    expect_bit("pok_o", pok, 1'b1);
    due = (due_q.size() != 0) && (due_q[0] == cycles);
    expect_bit("ctn_rsp_valid_o", rsp_valid, due);
    if (due) begin
      void'(due_q.pop_front());
      h = order_q.pop_front();
      match_rsp(rsp, exp_q[h].pop_front(), known_q[h].pop_front());
      responses++;
    end
    xfer = host_valid & exp_ready;
    for (int i = 0; i < CtnNumHosts; i++) if (xfer[i]) record_transfer(i);
  endtask

  // Both hosts wait on the fabric reset with a request pending
  task automatic raise_first_requests();
    for (int h = 0; h < CtnNumHosts; h++) begin
      host_req[h]   <= next_request(h);
      host_valid[h] <= 1'b1;
      issued[h]++;
    end
  endtask

  task automatic drive_hosts();
    for (int h = 0; h < CtnNumHosts; h++) begin
      if (xfer[h] || !host_valid[h]) begin
        if (issued[h] < NumReqs && ($random(seed) & 3) != 0) begin
          host_req[h]   <= next_request(h);
          host_valid[h] <= 1'b1;
          issued[h]++;
        end else begin
          host_valid[h] <= 1'b0;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Clock, timeout and main sequence
  ////////////////////////////////////////

  initial begin
    clk_aon = 1'b0;
    forever #50 clk_aon = ~clk_aon;
  end

  always @(posedge clk_aon) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles)
      report_failure($sformatf("Timeout: traffic did not finish within %0d cycles", cycles));
  end

  initial begin
    seed          = 32'h5e73_ad84;
    cycles        = 0;
    rst_n_i       = 1'b0;
    host_valid    = '0;
    host_req      = '0;
    xfer          = '0;
    have_last     = 1'b0;
    last_host     = 0;
    responses     = 0;
    reads_checked = 0;
    for (int i = 0; i < CtnNumHosts; i++) issued[i] = 0;
    for (int w = 0; w < 2**CtnRamAw; w++) model_known[w] = '0;
    repeat (8) @(posedge clk_aon);
    rst_n_i <= 1'b1;
    // Supply pattern, hosts start asking once the glitch is over
    for (int k = 0; k < PorCheckLen; k++) begin
      if (k == HostStart) begin
        @(posedge clk_aon);
        raise_first_requests();
      end
      @(negedge clk_aon);
      expect_bit("pok_o", pok, pok_pattern(k));
      expect_bit("ctn_rsp_valid_o", rsp_valid, 1'b0);
      for (int i = 0; i < CtnNumHosts; i++)
        expect_bit($sformatf("host_ready_o[%0d]", i), host_ready[i], 1'b0);
    end
    while (issued[0] < NumReqs || issued[1] < NumReqs || host_valid != '0 ||
           due_q.size() != 0) begin
      @(posedge clk_aon);
      drive_hosts();
      @(negedge clk_aon);
      sample_cycle();
    end
    $display("%0d responses, %0d reads compared against written data", responses, reads_checked);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* logic/ctn_subsys_top.sv */
////////////////////////////////////////
// Always-on CTN subsystem top level
// Power-on sequencer, host merge, SRAM adapter and RAM on clk_aon
////////////////////////////////////////

`timescale 1ns/1ps

module ctn_subsys_top (
  input  logic                                          clk_aon,
  input  logic                                          rst_n_i,
  input  logic [ctn_pkg::CtnNumHosts-1:0]               host_valid_i,
  input  ctn_pkg::ctn_req_t [ctn_pkg::CtnNumHosts-1:0]  host_req_i,
  output logic [ctn_pkg::CtnNumHosts-1:0]               host_ready_o,
  output logic                                          ctn_rsp_valid_o,
  output ctn_pkg::ctn_rsp_t                             ctn_rsp_o,
  output logic                                          pok_o
);

  import ctn_pkg::*;

  logic                fabric_rst_n;
  logic                arb_valid;
  ctn_req_t            arb_req;
  logic                ram_cmd_valid;
  ctn_ram_cmd_t        ram_cmd;
  logic                ram_rsp_valid;
  logic [CtnDataW-1:0] ram_rdata;
  ctn_ram_tag_t        ram_tag;

  ////////////////////////////////////////
  // Power-on sequence
  ////////////////////////////////////////

  por_sequencer u_por_seq (
    .rst_n_i        (rst_n_i),
    .clk_aon        (clk_aon),
    .pok_o          (pok_o),
    .fabric_rst_n_o (fabric_rst_n)
  );

  ////////////////////////////////////////
  // CTN memory path
  ////////////////////////////////////////

  ctn_host_arbiter u_host_arb (
    .clk_aon        (clk_aon),
    .fabric_rst_n_i (fabric_rst_n),
    .host_valid_i   (host_valid_i),
    .host_req_i     (host_req_i),
    .host_ready_o   (host_ready_o),
    .arb_valid_o    (arb_valid),
    .arb_req_o      (arb_req)
  );

  ctn_sram_adapter u_sram_adapter (
    .clk_aon         (clk_aon),
    .fabric_rst_n_i  (fabric_rst_n),
    .arb_valid_i     (arb_valid),
    .arb_req_i       (arb_req),
    .ram_cmd_valid_o (ram_cmd_valid),
    .ram_cmd_o       (ram_cmd),
    .ram_rsp_valid_i (ram_rsp_valid),
    .ram_rdata_i     (ram_rdata),
    .ram_tag_i       (ram_tag),
    .rsp_valid_o     (ctn_rsp_valid_o),
    .rsp_o           (ctn_rsp_o)
  );

  // RAM always grants
  ctn_ram u_ctn_ram (
    .clk_aon        (clk_aon),
    .fabric_rst_n_i (fabric_rst_n),
    .cmd_valid_i    (ram_cmd_valid),
    .cmd_i          (ram_cmd),
    .rsp_valid_o    (ram_rsp_valid),
    .rdata_o        (ram_rdata),
    .tag_o          (ram_tag)
  );

endmodule

/* logic/ctn_ram.sv */
////////////////////////////////////////
// Single-port CTN RAM with byte strobes
// Input register and output register give two cycles of latency
////////////////////////////////////////

`timescale 1ns/1ps

module ctn_ram (
  input  logic                          clk_aon,
  input  logic                          fabric_rst_n_i,
  input  logic                          cmd_valid_i,
  input  ctn_pkg::ctn_ram_cmd_t         cmd_i,
  output logic                          rsp_valid_o,
  output logic [ctn_pkg::CtnDataW-1:0]  rdata_o,
  output ctn_pkg::ctn_ram_tag_t         tag_o
);

  import ctn_pkg::*;

  logic [CtnDataW-1:0] mem [2**CtnRamAw];

  ctn_ram_cmd_t        cmd_q;
  logic                cmd_valid_q;
  logic                rsp_valid_q;
  logic [CtnDataW-1:0] rdata_q;
  ctn_ram_tag_t        tag_q;

  ////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!fabric_rst_n_i) begin
      cmd_valid_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= cmd_valid_i;
      rsp_valid_q <= cmd_valid_q;
    end
  end

  always_ff @(posedge clk_aon) begin
    if (cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
  end

  // Array access from the registered command
  always_ff @(posedge clk_aon) begin
    if (cmd_valid_q && cmd_q.we) begin
      for (int b = 0; b < CtnMaskW; b++) begin
        if (cmd_q.wmask[b]) begin
          mem[cmd_q.addr][8*b +: 8] <= cmd_q.wdata[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (cmd_valid_q) begin
      rdata_q <= cmd_q.we ? '0 : mem[cmd_q.addr];  // Writes return zero
      tag_q   <= cmd_q.tag;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign tag_o       = tag_q;

endmodule

/* logic/ctn_sram_adapter.sv */
////////////////////////////////////////
// Window check and word translation in front of the CTN RAM
// Builds in-order responses from the tag that returns with the data
////////////////////////////////////////

`timescale 1ns/1ps

module ctn_sram_adapter (
  input  logic                          clk_aon,
  input  logic                          fabric_rst_n_i,
  // Merged request stream
  input  logic                          arb_valid_i,
  input  ctn_pkg::ctn_req_t             arb_req_i,
  // RAM command side
  output logic                          ram_cmd_valid_o,
  output ctn_pkg::ctn_ram_cmd_t         ram_cmd_o,
  // RAM return side
  input  logic                          ram_rsp_valid_i,
  input  logic [ctn_pkg::CtnDataW-1:0]  ram_rdata_i,
  input  ctn_pkg::ctn_ram_tag_t         ram_tag_i,
  // Response to the hosts
  output logic                          rsp_valid_o,
  output ctn_pkg::ctn_rsp_t             rsp_o
);

  import ctn_pkg::*;

  logic         in_window;
  ctn_ram_cmd_t cmd_d;
  ctn_ram_cmd_t cmd_q;
  logic         cmd_valid_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Window is size aligned so a masked compare is enough
  assign in_window = (arb_req_i.addr & ~(CtnAddrW'(CtnRamSizeBytes) - 1'b1)) == CtnRamBase;

  always_comb begin
    cmd_d             = '0;
    cmd_d.we          = in_window && (arb_req_i.op == CtnWrite);
    cmd_d.addr        = arb_req_i.addr[CtnRamAw+1:2];  // Byte offset to word index
    cmd_d.wdata       = arb_req_i.wdata;
    cmd_d.wmask       = arb_req_i.wmask;
    cmd_d.tag.err     = !in_window;
    cmd_d.tag.host_id = arb_req_i.host_id;
  end

  ////////////////////////////////////////
  // Command register
  ////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!fabric_rst_n_i) begin
      cmd_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= arb_valid_i;
    end
  end

  // Misses still go down the pipe to keep order and latency
  always_ff @(posedge clk_aon) begin
    if (arb_valid_i) begin
      cmd_q <= cmd_d;
    end
  end

  assign ram_cmd_valid_o = cmd_valid_q;
  assign ram_cmd_o       = cmd_q;

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_comb begin
    rsp_valid_o   = ram_rsp_valid_i;
    rsp_o.err     = ram_tag_i.err;
    rsp_o.host_id = ram_tag_i.host_id;
    rsp_o.rdata   = ram_tag_i.err ? '0 : ram_rdata_i;  // Error carries no data
  end

endmodule

/* logic/ctn_host_arbiter.sv */
////////////////////////////////////////
// Round-robin merge of the CTN host ports into one request stream
// Grant is combinational, the downstream side never stalls
////////////////////////////////////////

`timescale 1ns/1ps

module ctn_host_arbiter (
  input  logic                                           clk_aon,
  input  logic                                           fabric_rst_n_i,
  input  logic [ctn_pkg::CtnNumHosts-1:0]                host_valid_i,
  input  ctn_pkg::ctn_req_t [ctn_pkg::CtnNumHosts-1:0]   host_req_i,
  output logic [ctn_pkg::CtnNumHosts-1:0]                host_ready_o,
  output logic                                           arb_valid_o,
  output ctn_pkg::ctn_req_t                              arb_req_o
);

  import ctn_pkg::*;

  logic [CtnHostIdW-1:0] last_q;     // Host granted most recently
  logic [CtnHostIdW-1:0] gnt_idx;
  logic                  gnt_found;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  // Search starts one past the last winner
  always_comb begin
    int cand;

    cand      = 0;
    gnt_found = 1'b0;
    gnt_idx   = last_q;
    for (int i = 1; i <= CtnNumHosts; i++) begin
      cand = (int'(last_q) + i) % CtnNumHosts;
      if (!gnt_found && host_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = CtnHostIdW'(cand);
      end
    end

    // Nothing moves while the fabric is held in reset
    if (!fabric_rst_n_i) begin
      gnt_found = 1'b0;
    end
  end

  always_comb begin
    host_ready_o          = '0;
    host_ready_o[gnt_idx] = gnt_found;
    arb_valid_o           = gnt_found;
    arb_req_o             = host_req_i[gnt_idx];
    arb_req_o.host_id     = gnt_idx;  // Port index routes the response
  end

  ////////////////////////////////////////
  // Round-robin pointer
  ////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!fabric_rst_n_i) begin
      last_q <= CtnHostIdW'(CtnNumHosts - 1);  // Host 0 wins the first tie
    end else if (gnt_found) begin
      last_q <= gnt_idx;
    end
  end

endmodule

/* logic/por_sequencer.sv */
////////////////////////////////////////
// Platform power-on sequence on the always-on clock
// Drives a low/high/low/high supply-good pattern and the fabric reset
////////////////////////////////////////

`timescale 1ns/1ps

module por_sequencer (
  input  logic rst_n_i,
  input  logic clk_aon,
  output logic pok_o,
  output logic fabric_rst_n_o
);

  import ctn_pkg::*;

  logic [3:0] cnt_q;
  por_state_e por_state;
  logic       fabric_rst_n_q;

  ////////////////////////////////////////
  // Supply counter
  ////////////////////////////////////////

  // Counts up once per cycle and sticks at all ones
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q != 4'hf) begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  // Three equal phases before the supply settles
  always_comb begin
    if (cnt_q < 4'(PorStableCount / 3)) begin
      por_state = PorRampLow;
    end else if (cnt_q < 4'(2 * PorStableCount / 3)) begin
      por_state = PorGlitchHigh;  // Short false start
    end else if (cnt_q < 4'(PorStableCount)) begin
      por_state = PorDipLow;
    end else begin
      por_state = PorStable;
    end
  end

  assign pok_o = (por_state == PorGlitchHigh) || (por_state == PorStable);

  ////////////////////////////////////////
  // Fabric reset
  ////////////////////////////////////////

  // Glitch high is passed on, so the fabric is reset twice
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      fabric_rst_n_q <= 1'b0;
    end else begin
      fabric_rst_n_q <= pok_o;
    end
  end

  assign fabric_rst_n_o = fabric_rst_n_q;

endmodule

/* logic/ctn_pkg.sv */
////////////////////////////////////////
// Shared types and constants for the CTN memory path
// and the always-on power-on sequencer
////////////////////////////////////////

package ctn_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  localparam int CtnNumHosts = 2;
  localparam int CtnHostIdW  = 1;
  localparam int CtnAddrW    = 32;
  localparam int CtnDataW    = 32;
  localparam int CtnMaskW    = CtnDataW / 8;  // One strobe per byte

  ////////////////////////////////////////
  // RAM window
  ////////////////////////////////////////

  localparam int                  CtnRamAw        = 8;             // 256 words
  localparam logic [CtnAddrW-1:0] CtnRamBase      = 32'h0001_0000;
  localparam int                  CtnRamSizeBytes = 1024;
  localparam int                  CtnRspLatency   = 3;             // Accept edge to response

  // Counter value where the supply pattern settles
  localparam int PorStableCount = 12;

  typedef enum logic {
    CtnRead  = 1'b0,
    CtnWrite = 1'b1
  } ctn_op_e;

  // Supply-good phases of the power-on sequence
  typedef enum logic [1:0] {
    PorRampLow    = 2'd0,
    PorGlitchHigh = 2'd1,
    PorDipLow     = 2'd2,
    PorStable     = 2'd3
  } por_state_e;

  typedef struct packed {
    ctn_op_e               op;
    logic [CtnAddrW-1:0]   addr;
    logic [CtnDataW-1:0]   wdata;
    logic [CtnMaskW-1:0]   wmask;
    logic [CtnHostIdW-1:0] host_id;
  } ctn_req_t;

  typedef struct packed {
    logic [CtnDataW-1:0]   rdata;
    logic                  err;
    logic [CtnHostIdW-1:0] host_id;
  } ctn_rsp_t;

  // Rides through the RAM pipeline untouched
  typedef struct packed {
    logic                  err;
    logic [CtnHostIdW-1:0] host_id;
  } ctn_ram_tag_t;

  typedef struct packed {
    logic                we;
    logic [CtnRamAw-1:0] addr;  // Word address
    logic [CtnDataW-1:0] wdata;
    logic [CtnMaskW-1:0] wmask;
    ctn_ram_tag_t        tag;
  } ctn_ram_cmd_t;

endpackage
